/* hdl/mini_core_pkg.sv */
// mini core shared definitions
package mini_core_pkg;

    // ====================
    // fabric side
    // ====================
    typedef enum logic [1:0] {
        FAB_WR = 2'b01,
        FAB_RD = 2'b10
    } t_fab_op;

    typedef struct packed {
        t_fab_op     op;
        logic [31:0] address;   // byte address, word aligned
        logic [31:0] data;      // write data, unused on reads
    } t_fab_req;

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] address;   // echoed so responses pair with requests
    } t_fab_rsp;

    // shared memory port request
    typedef struct packed {
        logic        wr;
        logic [31:0] address;
        logic [31:0] wdata;
    } t_mem_req;

    // ====================
    // instruction formats
    // ====================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_r_instr;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_i_instr;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } t_s_instr;

    typedef union packed {
        t_r_instr r;
        t_i_instr i;
        t_s_instr s;
    } t_instr;

    // opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [6:0]  F7_ADD      = 7'b0000000;
    localparam logic [6:0]  F7_SUB      = 7'b0100000;
    localparam logic [2:0]  F3_ADD      = 3'b000;     // add, sub, addi
    localparam logic [2:0]  F3_WORD     = 3'b010;     // lw, sw
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // ====================
    // address map
    // ====================
    localparam int         REGION_LSB  = 12;     // bits 13:12 pick the region
    localparam logic [1:0] REGION_IMEM = 2'd0;
    localparam logic [1:0] REGION_DMEM = 2'd1;
    localparam logic [1:0] REGION_CTRL = 2'd2;

endpackage

/* hdl/mini_fabric_if.sv */
// fabric request and response port
`timescale 1ns/1ns
module mini_fabric_if
    import mini_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fab_req_valid,  // one cycle strobe, no back-pressure
    input  t_fab_req    fab_req,
    output logic        fab_rsp_valid,
    output t_fab_rsp    fab_rsp,
    output logic        fab_mem_valid,
    output t_mem_req    fab_mem_req,
    input  logic        fab_rd_valid,   // read data for the fabric is on mem_rdata
    input  logic [31:0] mem_rdata
);
    logic        is_rd;
    logic        is_wr;
    logic [31:0] rd_addr_q;     // address of the read in the memory stage

    assign is_rd = (fab_req.op == FAB_RD);
    assign is_wr = (fab_req.op == FAB_WR);

    // straight through to the arbiter, same cycle as the strobe
    assign fab_mem_valid       = fab_req_valid && (is_rd || is_wr);
    assign fab_mem_req.wr      = is_wr;
    assign fab_mem_req.address = fab_req.address;
    assign fab_mem_req.wdata   = fab_req.data;

    // address follows its read by one cycle to meet the data
    always_ff @(posedge clk) begin
        if (fab_req_valid && is_rd) rd_addr_q <= fab_req.address;
    end

    // ====================
    // response register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) fab_rsp_valid <= 1'b0;
        else        fab_rsp_valid <= fab_rd_valid;
    end

    always_ff @(posedge clk) begin
        if (fab_rd_valid) begin
            fab_rsp.data    <= mem_rdata;
            fab_rsp.address <= rd_addr_q;
        end
    end

endmodule

/* hdl/mini_mem_arb.sv */
// fixed priority memory arbiter
`timescale 1ns/1ns
module mini_mem_arb
    import mini_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fab_mem_valid,     // fabric always wins
    input  t_mem_req fab_mem_req,
    input  logic     core_mem_valid,    // held until granted
    input  t_mem_req core_mem_req,
    output logic     core_mem_gnt,
    output logic     mem_valid,
    output t_mem_req mem_req,
    input  logic     mem_rd_valid,      // one cycle after a read
    output logic     fab_rd_valid,
    output logic     core_rd_valid
);
    logic rd_owner_fab_q;   // 1: read in flight belongs to the fabric

    // core gets the port only in idle fabric cycles
    assign core_mem_gnt = core_mem_valid && !fab_mem_valid;
    assign mem_valid    = fab_mem_valid || core_mem_valid;
    assign mem_req      = fab_mem_valid ? fab_mem_req : core_mem_req;

    // ====================
    // read owner tracking
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rd_owner_fab_q <= 1'b0;
        else        rd_owner_fab_q <= fab_mem_valid && !fab_mem_req.wr;
    end

    // steer the late read valid to whoever issued it
    assign fab_rd_valid  = mem_rd_valid && rd_owner_fab_q;
    assign core_rd_valid = mem_rd_valid && !rd_owner_fab_q;

endmodule

/* hdl/mini_mem_wrap.sv */
// shared tile memory
`timescale 1ns/1ns
module mini_mem_wrap
    import mini_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,     // words
    parameter int DMEM_DEPTH = 256      // words
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_valid,
    input  t_mem_req    mem_req,
    output logic        mem_rd_valid,
    output logic [31:0] mem_rdata,      // registered, one cycle after the read
    input  logic        halted,
    input  logic        illegal,
    output logic        run
);
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] dmem [DMEM_DEPTH];

    logic [1:0]         region;
    logic [IMEM_AW-1:0] imem_idx;   // upper bits dropped, so addresses wrap
    logic [DMEM_AW-1:0] dmem_idx;

    assign region   = mem_req.address[REGION_LSB +: 2];
    assign imem_idx = mem_req.address[2 +: IMEM_AW];
    assign dmem_idx = mem_req.address[2 +: DMEM_AW];

    // ====================
    // arrays and read port
    // ====================
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            if (mem_req.wr) begin
                if (region == REGION_IMEM) imem[imem_idx] <= mem_req.wdata;
                if (region == REGION_DMEM) dmem[dmem_idx] <= mem_req.wdata;
            end else begin
                case (region)
                    REGION_IMEM: mem_rdata <= imem[imem_idx];
                    REGION_DMEM: mem_rdata <= dmem[dmem_idx];
                    REGION_CTRL: mem_rdata <= {29'b0, illegal, halted, run};  // status word
                    default:     mem_rdata <= '0;   // unmapped region
                endcase
            end
        end
    end

    // ====================
    // control word and read valid
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run          <= 1'b0;
            mem_rd_valid <= 1'b0;
        end else begin
            mem_rd_valid <= mem_valid && !mem_req.wr;
            if (mem_valid && mem_req.wr && region == REGION_CTRL)
                run <= mem_req.wdata[0];    // bit 0 starts or stops the core
        end
    end

endmodule

/* hdl/mini_core.sv */
// mini core multi-cycle rv32i subset
`timescale 1ns/1ns
module mini_core
    import mini_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256      // words, pc wraps here
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    output logic        core_mem_valid,
    output t_mem_req    core_mem_req,
    input  logic        core_mem_gnt,
    input  logic        core_rd_valid,
    input  logic [31:0] mem_rdata,
    output logic        halted,
    output logic        illegal
);
    localparam int PC_W = $clog2(IMEM_DEPTH);

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_LOAD, S_HALT
    } t_state;

    t_state          state_q;
    logic [PC_W-1:0] pc_q;          // word index into imem
    logic [PC_W-1:0] pc_next;
    t_instr          instr_q;
    logic [31:0]     rf [32];       // x0 never written, reads as zero

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] alu_res;
    logic [31:0] data_sum;
    logic [31:0] fetch_addr;
    logic        is_add;
    logic        is_sub;
    logic        is_addi;
    logic        is_lw;
    logic        is_sw;
    logic        is_ebreak;
    logic        rf_we;
    logic [31:0] rf_wdata;

    // ====================
    // decode
    // ====================
    assign is_add    = instr_q.r.opcode == OP_R && instr_q.r.funct3 == F3_ADD
                       && instr_q.r.funct7 == F7_ADD;
    assign is_sub    = instr_q.r.opcode == OP_R && instr_q.r.funct3 == F3_ADD
                       && instr_q.r.funct7 == F7_SUB;
    assign is_addi   = instr_q.i.opcode == OP_IMM && instr_q.i.funct3 == F3_ADD;
    assign is_lw     = instr_q.i.opcode == OP_LOAD && instr_q.i.funct3 == F3_WORD;
    assign is_sw     = instr_q.s.opcode == OP_STORE && instr_q.s.funct3 == F3_WORD;
    assign is_ebreak = instr_q == EBREAK_WORD;      // only legal system op

    assign imm_i = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};

    // rs1 and rs2 sit at the same bits in every format
    assign rs1_val = (instr_q.r.rs1 == 5'd0) ? '0 : rf[instr_q.r.rs1];
    assign rs2_val = (instr_q.r.rs2 == 5'd0) ? '0 : rf[instr_q.r.rs2];

    assign alu_res  = is_sub  ? rs1_val - rs2_val :
                      is_addi ? rs1_val + imm_i : rs1_val + rs2_val;
    assign data_sum = rs1_val + (is_sw ? imm_s : imm_i);
    assign pc_next  = (pc_q == PC_W'(IMEM_DEPTH - 1)) ? '0 : pc_q + 1'b1;

    always_comb begin
        fetch_addr                    = '0;
        fetch_addr[2 +: PC_W]         = pc_q;
        fetch_addr[REGION_LSB +: 2]   = REGION_IMEM;
    end

    // ====================
    // bus request, steady while waiting for the grant
    // ====================
    always_comb begin
        core_mem_valid = (state_q == S_FETCH) || (state_q == S_MEM);
        core_mem_req.wr      = (state_q == S_MEM) && is_sw;
        core_mem_req.wdata   = rs2_val;
        core_mem_req.address = fetch_addr;
        if (state_q == S_MEM) begin
            core_mem_req.address = data_sum;
            core_mem_req.address[REGION_LSB +: 2] = REGION_DMEM;   // data goes to dmem
        end
    end

    // ====================
    // register file
    // ====================
    assign rf_we    = (state_q == S_EXEC && (is_add || is_sub || is_addi))
                      || (state_q == S_LOAD && core_rd_valid);
    assign rf_wdata = (state_q == S_LOAD) ? mem_rdata : alu_res;

    always_ff @(posedge clk) begin
        if (rf_we && instr_q.r.rd != 5'd0) rf[instr_q.r.rd] <= rf_wdata;
        if (state_q == S_DECODE && core_rd_valid) instr_q <= mem_rdata;
    end

    // ====================
    // control fsm
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            pc_q    <= '0;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (run) begin
                    state_q <= S_FETCH;
                    pc_q    <= '0;      // every start begins at word 0
                end
                S_FETCH:  if (core_mem_gnt) state_q <= S_DECODE;
                S_DECODE: if (core_rd_valid) state_q <= S_EXEC;
                S_EXEC: begin
                    if (is_ebreak) begin
                        state_q <= S_HALT;
                        halted  <= 1'b1;
                    end else if (is_add || is_sub || is_addi) begin
                        state_q <= S_FETCH;
                        pc_q    <= pc_next;
                    end else if (is_lw || is_sw) begin
                        state_q <= S_MEM;
                        pc_q    <= pc_next;     // data access uses instr_q only
                    end else begin
                        state_q <= S_HALT;      // unknown opcode
                        halted  <= 1'b1;
                        illegal <= 1'b1;
                    end
                end
                S_MEM:  if (core_mem_gnt) state_q <= is_lw ? S_LOAD : S_FETCH;
                S_LOAD: if (core_rd_valid) state_q <= S_FETCH;
                S_HALT: if (!run) begin         // cleared run rearms the core
                    state_q <= S_IDLE;
                    halted  <= 1'b0;
                    illegal <= 1'b0;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

/* hdl/mini_core_top.sv */
// mini core tile top
`timescale 1ns/1ns
module mini_core_top
    import mini_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fab_req_valid,
    input  t_fab_req fab_req,
    output logic     fab_rsp_valid,
    output t_fab_rsp fab_rsp
);
    logic        fab_mem_valid;
    t_mem_req    fab_mem_req;
    logic        core_mem_valid;
    t_mem_req    core_mem_req;
    logic        core_mem_gnt;
    logic        mem_valid;
    t_mem_req    mem_req;
    logic        mem_rd_valid;
    logic [31:0] mem_rdata;     // shared by both readers
    logic        fab_rd_valid;
    logic        core_rd_valid;
    logic        run;
    logic        halted;
    logic        illegal;

    mini_fabric_if mini_fabric_if (
        .clk           (clk),
        .rst_n         (rst_n),
        .fab_req_valid (fab_req_valid),
        .fab_req       (fab_req),
        .fab_rsp_valid (fab_rsp_valid),
        .fab_rsp       (fab_rsp),
        .fab_mem_valid (fab_mem_valid),
        .fab_mem_req   (fab_mem_req),
        .fab_rd_valid  (fab_rd_valid),
        .mem_rdata     (mem_rdata)
    );

    mini_mem_arb mini_mem_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .fab_mem_valid  (fab_mem_valid),
        .fab_mem_req    (fab_mem_req),
        .core_mem_valid (core_mem_valid),
        .core_mem_req   (core_mem_req),
        .core_mem_gnt   (core_mem_gnt),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .mem_rd_valid   (mem_rd_valid),
        .fab_rd_valid   (fab_rd_valid),
        .core_rd_valid  (core_rd_valid)
    );

    mini_mem_wrap #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mini_mem_wrap (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_rd_valid (mem_rd_valid),
        .mem_rdata    (mem_rdata),
        .halted       (halted),
        .illegal      (illegal),
        .run          (run)
    );

    mini_core #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) mini_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .run            (run),
        .core_mem_valid (core_mem_valid),
        .core_mem_req   (core_mem_req),
        .core_mem_gnt   (core_mem_gnt),
        .core_rd_valid  (core_rd_valid),
        .mem_rdata      (mem_rdata),
        .halted         (halted),
        .illegal        (illegal)
    );

endmodule

/* verif/mini_core_chk.sv */
// fabric response checker
`timescale 1ns/1ns
module mini_core_chk
    import mini_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fab_req_valid,
    input  t_fab_req    fab_req,
    input  logic [31:0] exp_data,       // travels with each read strobe
    input  logic [31:0] exp_mask,       // zero bits are not compared
    input  logic        fab_rsp_valid,
    input  t_fab_rsp    fab_rsp,
    output int          errors,
    output int          pending         // reads still waiting for their response
);
    localparam int RSP_LATENCY = 2;     // strobe to response, in cycles

    int          cycle;
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] mask_q [$];
    int          cycle_q [$];           // cycle each read was seen

    initial begin
        errors  = 0;
        pending = 0;
        cycle   = 0;
    end

    // oldest outstanding read pairs with this response
    task automatic check_response();
        logic [31:0] e_addr;
        logic [31:0] e_data;
        logic [31:0] e_mask;
        int          age;
        if (addr_q.size() == 0) begin
            $display("t=%0t response arrived with no read outstanding", $time);
            errors++;
        end else begin
            e_addr = addr_q.pop_front();
            e_data = data_q.pop_front();
            e_mask = mask_q.pop_front();
            age    = cycle - cycle_q.pop_front();
            if (age != RSP_LATENCY) begin
                $display("CHECK FAILED t=%0t fab_rsp_valid latency got %0d expected %0d",
                         $time, age, RSP_LATENCY);
                errors++;
            end
            if (fab_rsp.address !== e_addr) begin
                $display("CHECK FAILED t=%0t fab_rsp.address got %h expected %h",
                         $time, fab_rsp.address, e_addr);
                errors++;
            end
            if ((fab_rsp.data & e_mask) !== (e_data & e_mask)) begin
                $display("CHECK FAILED t=%0t fab_rsp.data got %h expected %h (addr %h)",
                         $time, fab_rsp.data, e_data, e_addr);
                errors++;
            end
        end
    endtask

    // ====================
    // per cycle monitor
    // ====================
    always @(posedge clk) begin
        if (!rst_n) begin
            addr_q.delete();
            data_q.delete();
            mask_q.delete();
            cycle_q.delete();
        end else begin
            cycle++;
            if (fab_rsp_valid) check_response();
            // read older than the latency lost its response
            if (cycle_q.size() != 0 && cycle - cycle_q[0] > RSP_LATENCY) begin
                $display("t=%0t no response for read of %h", $time, addr_q[0]);
                errors++;
                void'(addr_q.pop_front());
                void'(data_q.pop_front());
                void'(mask_q.pop_front());
                void'(cycle_q.pop_front());
            end
            if (fab_req_valid && fab_req.op == FAB_RD) begin
                addr_q.push_back(fab_req.address);
                data_q.push_back(exp_data);
                mask_q.push_back(exp_mask);
                cycle_q.push_back(cycle);
            end
        end
        pending = addr_q.size();
    end

endmodule

/* verif/mini_core_tb.sv */
// mini core tile testbench
`timescale 1ns/1ns
module mini_core_tb
    import mini_core_pkg::*;
();
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 10;
    localparam int          DRIVE_DELAY   = 2;      // inputs move after the edge
    localparam int          WDOG_PER_LINE = 200;    // cycles per golden line
    localparam int          MAX_POLLS     = 200;
    localparam logic [31:0] CTRL_ADDR     = 32'h0000_2000;
    localparam logic [31:0] BURST_BASE    = 32'h0000_1300;  // dmem words kept for bursts
    localparam logic [31:0] LCG_SEED      = 32'h65be;
    localparam string       GOLDEN_FILE   = "verif/mini_core_golden.txt";

    logic        clk;
    logic        rst_n;
    logic        fab_req_valid;
    t_fab_req    fab_req;
    logic        fab_rsp_valid;
    t_fab_rsp    fab_rsp;
    logic [31:0] exp_data;
    logic [31:0] exp_mask;
    int          chk_errors;
    int          chk_pending;
    int          drv_errors;
    logic [31:0] lcg_state;
    bit          golden_loaded;
    logic [7:0]  line_tag [$];
    logic [31:0] line_a [$];
    logic [31:0] line_b [$];

    mini_core_top #(
        .IMEM_DEPTH (256),
        .DMEM_DEPTH (256)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fab_req_valid (fab_req_valid),
        .fab_req       (fab_req),
        .fab_rsp_valid (fab_rsp_valid),
        .fab_rsp       (fab_rsp)
    );

    mini_core_chk chk (
        .clk           (clk),
        .rst_n         (rst_n),
        .fab_req_valid (fab_req_valid),
        .fab_req       (fab_req),
        .exp_data      (exp_data),
        .exp_mask      (exp_mask),
        .fab_rsp_valid (fab_rsp_valid),
        .fab_rsp       (fab_rsp),
        .errors        (chk_errors),
        .pending       (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ====================
    // golden file
    // ====================
    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                tag = line.getc(0);
                a   = '0;
                b   = '0;
                n   = 0;
                if (tag == "W" || tag == "R" || tag == "P" || tag == "H") begin
                    if (tag == "P") n = $sscanf(line.substr(1, line.len() - 1), "%d", a);
                    else if (tag != "H")
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    if ((tag == "W" || tag == "R") && n != 2) begin
                        $display("malformed golden line: %s", line);
                        drv_errors++;
                    end
                    line_tag.push_back(tag);
                    line_a.push_back(a);
                    line_b.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // fabric driver entered and left at edge plus DRIVE_DELAY
    // ====================
    task automatic drive_req(input t_fab_op op, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] exp_d,
                             input logic [31:0] exp_m);
        fab_req_valid   = 1'b1;
        fab_req.op      = op;
        fab_req.address = addr;
        fab_req.data    = data;
        exp_data        = exp_d;
        exp_mask        = exp_m;
        @(posedge clk);
        #DRIVE_DELAY;
        fab_req_valid = 1'b0;      // one cycle strobe
    endtask

    task automatic run_burst(input int count);
        logic [31:0] words [$];
        for (int i = 0; i < count; i++) begin
            lcg_state = lcg_next(lcg_state);
            words.push_back(lcg_state);
            drive_req(FAB_WR, BURST_BASE + 32'(4 * i), lcg_state, '0, '0);
        end
        for (int i = 0; i < count; i++)     // reads on consecutive cycles
            drive_req(FAB_RD, BURST_BASE + 32'(4 * i), '0, words[i], '1);
    endtask

    // status polls keep their latency and address checks
    task automatic wait_halt();
        int polls;
        int waited;
        bit halted_seen;
        polls       = 0;
        halted_seen = 1'b0;
        while (!halted_seen && polls < MAX_POLLS) begin
            drive_req(FAB_RD, CTRL_ADDR, '0, '0, '0);
            waited = 0;
            while (!(fab_rsp_valid && fab_rsp.address == CTRL_ADDR) && waited < 8) begin
                @(posedge clk);
                #DRIVE_DELAY;
                waited++;
            end
            if (fab_rsp_valid && fab_rsp.address == CTRL_ADDR)
                halted_seen = fab_rsp.data[1];  // halted bit
            polls++;
        end
        if (!halted_seen) begin
            $display("t=%0t core never reported halted after %0d polls", $time, polls);
            drv_errors++;
        end
    endtask

    task automatic run_golden();
        for (int k = 0; k < line_tag.size(); k++) begin
            case (line_tag[k])
                "W":     drive_req(FAB_WR, line_a[k], line_b[k], '0, '0);
                "R":     drive_req(FAB_RD, line_a[k], '0, line_b[k], '1);
                "P":     run_burst(int'(line_a[k]));
                "H":     wait_halt();
                default: ;
            endcase
        end
    endtask

    // last responses reach the checker
    task automatic wait_drain();
        while (chk_pending != 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int total;
        rst_n           = 1'b0;
        fab_req_valid   = 1'b0;
        fab_req.op      = FAB_WR;
        fab_req.address = '0;
        fab_req.data    = '0;
        exp_data        = '0;
        exp_mask        = '0;
        drv_errors      = 0;
        lcg_state       = LCG_SEED;
        golden_loaded   = 1'b0;
        load_golden();
        if (line_tag.size() == 0) begin
            $display("no stimulus lines read from %s", GOLDEN_FILE);
            $display("TEST FAIL");
            $finish;
        end else begin
            golden_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            run_golden();
            wait_drain();
            total = chk_errors + drv_errors;
            $display("errors: checker %0d, driver %0d, total %0d",
                     chk_errors, drv_errors, total);
            if (total == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // watchdog scaled by the golden file length
    initial begin
        wait (golden_loaded);
        repeat (line_tag.size() * WDOG_PER_LINE) @(posedge clk);
        $display("timeout after %0d cycles, run did not finish",
                 line_tag.size() * WDOG_PER_LINE);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verif/mini_core_golden.txt */
# tag addr data: W write, R read with expected data, P burst of n words (decimal), H halt wait
# hex fields; regions 0000 imem, 1000 dmem, 2000 ctrl
W 000003f0 a5a5a5a5
W 000003f4 5a5a5a5a
W 00001080 12345678
W 0000110c deadbeef
W 00001200 cafef00d
W 00001204 0badc0de
R 000003f0 a5a5a5a5
R 000003f4 5a5a5a5a
R 00001080 12345678
R 0000110c deadbeef
P 32
# program 1: addi, add, sub, sw, lw round trip, x0 write, ebreak
W 00000000 00500093
W 00000004 ffd00113
W 00000008 002081b3
W 0000000c 40110233
W 00000010 10302023
W 00000014 10402223
W 00000018 08002283
W 0000001c 00128293
W 00000020 10502423
W 00000024 00708013
W 00000028 10002623
W 0000002c 00100073
W 00002000 00000001
R 00001200 cafef00d
R 00001204 0badc0de
P 16
H
R 00002000 00000003
R 00001100 00000002
R 00001104 fffffff8
R 00001108 12345679
R 0000110c 00000000
# program 2: addi, sw, then an unknown opcode
W 00002000 00000000
W 00000000 05500393
W 00000004 10702823
W 00000008 ffffffff
W 00002000 00000001
H
R 00002000 00000007
R 00001110 00000055
R 00001200 cafef00d

/* files.f */
hdl/mini_core_pkg.sv
hdl/mini_fabric_if.sv
hdl/mini_mem_arb.sv
hdl/mini_mem_wrap.sv
hdl/mini_core.sv
hdl/mini_core_top.sv
verif/mini_core_chk.sv
verif/mini_core_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing -Wno-fatal
TOP       := mini_core_tb
RTL_TOP   := mini_core_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
